//--- build.f
+incdir+test
src/geom_pkg.sv
src/matrix_store.sv
src/geom_cmd_ctrl.sv
src/vertex_transform.sv
src/persp_divide.sv
src/viewport_map.sv
src/geom_top.sv
test/tb_geom_top.sv

//--- Bender.yml
package:
  name: geom_pipe

sources:
  - files:
      - src/geom_pkg.sv
      - src/matrix_store.sv
      - src/geom_cmd_ctrl.sv
      - src/vertex_transform.sv
      - src/persp_divide.sv
      - src/viewport_map.sv
      - src/geom_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_geom_top.sv

//--- test/tb_geom_vectors.svh
`ifndef TB_GEOM_VECTORS_SVH
`define TB_GEOM_VECTORS_SVH

// Commands in issue order
// Vertex entries carry the expected screen x, y and z
task automatic build_table();
    // Identity matrix and full 640x480 viewport
    add_vp("vp_full", 0, 0, fx(640), fx(480));
    add_row("id_row0", 2'd0, fx(1), 0, 0, 0);
    add_row("id_row1", 2'd1, 0, fx(1), 0, 0);
    add_row("id_row2", 2'd2, 0, 0, fx(1), 0);
    add_row("id_row3", 2'd3, 0, 0, 0, fx(1));
    add_vertex("origin", 0, 0, 0, fx(1), fx(320), fx(240), 32'h0000_8000);
    add_vertex("half", 32'h0000_8000, 32'hFFFF_8000, 32'h0000_4000, fx(1),
               fx(480), fx(120), 32'h0000_A000);

    // Scale and translate
    add_row("st_row0", 2'd0, 32'h0000_8000, 0, 0, 32'h0000_4000);
    add_row("st_row1", 2'd1, 0, 32'h0000_4000, 0, 32'hFFFF_8000);
    add_row("st_row2", 2'd2, 0, 0, fx(2), 0);
    add_row("st_row3", 2'd3, 0, 0, 0, fx(1));
    // Negative dot products round toward minus infinity here
    add_vertex("st_floor", 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_2000, fx(1),
               32'h018F_FEC0, 32'h0077_FF10, 32'h0000_A000);
    add_vertex("st_unit", fx(1), fx(1), 32'h0000_2000, fx(1),
               fx(560), fx(180), 32'h0000_A000);

    // Row 3 copies z into w for the perspective divide
    add_row("pz_row0", 2'd0, fx(1), 0, 0, 0);
    add_row("pz_row1", 2'd1, 0, fx(1), 0, 0);
    add_row("pz_row2", 2'd2, 0, 0, fx(1), 0);
    add_row("pz_row3", 2'd3, 0, 0, fx(1), 0);
    add_vertex("persp_half", fx(1), fx(-1), fx(2), fx(1), fx(480), fx(120), fx(1));
    add_vertex("persp_trunc", fx(-1), fx(1), fx(3), fx(1),
               32'h00D5_55C0, 32'h013F_FFB0, fx(1));

    // Viewport change between vertices
    add_vertex("vp_before", fx(1), fx(-1), fx(2), fx(1), fx(480), fx(120), fx(1));
    add_vp("vp_small", fx(100), fx(50), fx(200), fx(100));
    add_vertex("vp_after", fx(1), fx(-1), fx(2), fx(1), fx(250), fx(75), fx(1));

    // Back-to-back burst
    add_vertex("burst_0", 0, 0, fx(1), fx(1), fx(200), fx(100), fx(1));
    add_vertex("burst_1", fx(2), fx(1), fx(4), fx(1), fx(250), 32'h0070_8000, fx(1));
    add_vertex("burst_2", fx(-3), fx(-1), fx(4), fx(1), fx(125), 32'h0057_8000, fx(1));
    add_vertex("burst_3", fx(1), fx(1), fx(1), fx(1), fx(300), fx(150), fx(1));
    add_vertex("burst_4", 32'h0000_8000, 0, fx(2), fx(1), fx(225), fx(100), fx(1));

    // Row 3 reload while the previous vertex is still in the transform
    add_vertex("pre_load", fx(1), 0, fx(1), fx(1), fx(300), fx(100), fx(1));
    add_row("double_w_row3", 2'd3, 0, 0, fx(2), 0);
    add_vertex("post_load", fx(1), 0, fx(1), fx(1), fx(250), fx(100), 32'h0000_C000);
endtask

`endif

//--- test/tb_geom_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_geom_top;
    import geom_pkg::*;

    localparam int FRAC_BITS     = 16;
    localparam int CMD_TIMEOUT   = 1000;  // Cycles
    localparam int OUT_TIMEOUT   = 2000;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int RESET_TIMEOUT = 100;

    logic      clk = 1'b0;
    logic      rst_n;
    geom_cmd_t cmd;
    logic      cmd_req;
    logic      cmd_ack;
    screen_t   scr;
    logic      out_req;
    logic      out_ack;

    // Command table
    string     name_tab[$];
    geom_cmd_t cmd_tab[$];
    bit        out_tab[$];
    screen_t   exp_tab[$];

    // Vertices issued but not yet seen at the output
    string     pend_name[$];
    screen_t   pend_exp[$];

    int err_count      = 0;
    int check_count    = 0;
    bit collector_busy = 1'b0;
    bit stop_collect   = 1'b0;

    geom_top #(.FRAC_BITS(FRAC_BITS)) uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (cmd),
        .cmd_req(cmd_req),
        .cmd_ack(cmd_ack),
        .scr    (scr),
        .out_req(out_req),
        .out_ack(out_ack)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Table helpers
    ////////////////////////////////////////////////////////////

    function automatic coord_t fx(input int n);
        return coord_t'(n * (1 << FRAC_BITS));
    endfunction

    function automatic vec4_t make_vec(input coord_t x, y, z, w);
        vec4_t v;
        v.x = x;
        v.y = y;
        v.z = z;
        v.w = w;
        return v;
    endfunction

    function automatic void push_entry(input string nm, input geom_cmd_t c,
                                       input bit has_out, input screen_t e);
        name_tab.push_back(nm);
        cmd_tab.push_back(c);
        out_tab.push_back(has_out);
        exp_tab.push_back(e);
    endfunction

    function automatic void add_row(input string nm, input row_idx_t r,
                                    input coord_t x, y, z, w);
        geom_cmd_t c;
        c.op   = CMD_LOAD_ROW;
        c.row  = r;
        c.data = make_vec(x, y, z, w);
        push_entry(nm, c, 1'b0, '0);
    endfunction

    function automatic void add_vp(input string nm, input coord_t x, y, width, height);
        geom_cmd_t c;
        c.op   = CMD_SET_VIEWPORT;
        c.row  = '0;
        c.data = make_vec(x, y, width, height);
        push_entry(nm, c, 1'b0, '0);
    endfunction

    function automatic void add_vertex(input string nm, input coord_t x, y, z, w,
                                       input coord_t ex, ey, ez);
        geom_cmd_t c;
        screen_t   e;
        c.op   = CMD_VERTEX;
        c.row  = '0;
        c.data = make_vec(x, y, z, w);
        e.x    = ex;
        e.y    = ey;
        e.z    = ez;
        push_entry(nm, c, 1'b1, e);
    endfunction

    `include "tb_geom_vectors.svh"

    ////////////////////////////////////////////////////////////
    // Handshake drivers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Summary: %0d checks, %0d errors before the abort", check_count, err_count);
        $display("Test FAILED");
        $finish;
    endtask

    // Four-phase command write, inputs change on the falling edge
    task automatic issue_cmd(input geom_cmd_t c, input string nm);
        int waited;
        @(negedge clk);
        cmd     = c;
        cmd_req = 1'b1;
        waited  = 0;
        while (!cmd_ack)
        begin
            @(negedge clk);
            waited++;
            if (waited > CMD_TIMEOUT)
                abort_run({"cmd_ack never rose for command ", nm});
        end
        cmd_req = 1'b0;
        waited  = 0;
        while (cmd_ack)
        begin
            @(negedge clk);
            waited++;
            if (waited > CMD_TIMEOUT)
                abort_run({"cmd_ack stayed high after command ", nm});
        end
    endtask

    initial
    begin : stimulus
        int waited;
        cmd     = '0;
        cmd_req = 1'b0;
        rst_n   = 1'b0;
        build_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_count++;
        if (cmd_ack !== 1'b0 || out_req !== 1'b0)
        begin
            err_count++;
            $display("FAIL after_reset: expected ack=0 req=0, actual ack=%b req=%b",
                     cmd_ack, out_req);
        end

        for (int i = 0; i < name_tab.size(); i++)
        begin
            if (out_tab[i])
            begin
                pend_name.push_back(name_tab[i]);
                pend_exp.push_back(exp_tab[i]);
            end
            issue_cmd(cmd_tab[i], name_tab[i]);
        end

        // Let the last vertices leave the pipe
        waited = 0;
        while (pend_exp.size() != 0 || collector_busy || out_req)
        begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT)
                abort_run("pipeline did not deliver all expected vertices");
        end
        stop_collect = 1'b1;

        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Output collector with random acknowledge delay
    ////////////////////////////////////////////////////////////

    initial
    begin : collector
        int      waited;
        int      delay;
        screen_t got;
        screen_t want;
        string   nm;
        out_ack = 1'b0;
        void'($urandom(43969));

        waited = 0;
        while (rst_n !== 1'b1)
        begin
            @(negedge clk);
            waited++;
            if (waited > RESET_TIMEOUT)
                abort_run("reset was never released");
        end

        while (!stop_collect)
        begin
            waited = 0;
            while (!out_req && !stop_collect)
            begin
                @(negedge clk);
                waited++;
                if (waited > OUT_TIMEOUT)
                    abort_run("no output vertex arrived in time");
            end
            if (out_req && !stop_collect)
            begin
                collector_busy = 1'b1;
                got = scr;
                if (pend_exp.size() == 0)
                begin
                    err_count++;
                    $display("ERROR: output vertex arrived with none expected");
                end
                else
                begin
                    want = pend_exp.pop_front();
                    nm   = pend_name.pop_front();
                    check_count++;
                    if (got !== want)
                    begin
                        err_count++;
                        $display("FAIL %s: expected (%h %h %h), actual (%h %h %h)",
                                 nm, want.x, want.y, want.z, got.x, got.y, got.z);
                    end
                end

                delay = $urandom % 8;
                repeat (delay) @(negedge clk);
                if (out_req !== 1'b1 || scr !== got)  // Must hold until acknowledged
                begin
                    err_count++;
                    $display("ERROR: out_req or scr changed before out_ack");
                end
                out_ack = 1'b1;

                waited = 0;
                while (out_req)
                begin
                    @(negedge clk);
                    waited++;
                    if (waited > OUT_TIMEOUT)
                        abort_run("out_req stayed high after out_ack");
                end
                out_ack        = 1'b0;
                collector_busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/geom_top.sv
`timescale 1ns/1ns
`default_nettype none

module geom_top #(
    parameter int FRAC_BITS = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  geom_pkg::geom_cmd_t cmd,
    input  logic                cmd_req,
    output logic                cmd_ack,
    output geom_pkg::screen_t   scr,
    output logic                out_req,
    input  logic                out_ack
);
    import geom_pkg::*;

    vec4_t    vtx;
    logic     vtx_valid;
    logic     vtx_ready;
    logic     row_load;
    row_idx_t row_sel;
    vec4_t    row_data;
    logic     vp_load;
    vec4_t    vp_data;
    mat4_t    rows;
    vec4_t    clip;
    logic     clip_valid;
    logic     clip_ready;
    ndc_t     ndc;
    logic     ndc_valid;
    logic     ndc_ready;
    logic     xform_idle;
    logic     div_idle;
    logic     vp_idle;
    logic     pipe_idle;

    assign pipe_idle = xform_idle && div_idle && vp_idle;  // Nothing in flight

    ////////////////////////////////////////////////////////////
    // Command side
    ////////////////////////////////////////////////////////////

    geom_cmd_ctrl u_cmd_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_req   (cmd_req),
        .cmd_ack   (cmd_ack),
        .vtx       (vtx),
        .vtx_valid (vtx_valid),
        .vtx_ready (vtx_ready),
        .row_load  (row_load),
        .row_sel   (row_sel),
        .row_data  (row_data),
        .vp_load   (vp_load),
        .vp_data   (vp_data),
        .xform_idle(xform_idle),
        .pipe_idle (pipe_idle)
    );

    matrix_store u_matrix (
        .clk     (clk),
        .rst_n   (rst_n),
        .row_load(row_load),
        .row_sel (row_sel),
        .row_data(row_data),
        .rows    (rows)
    );

    ////////////////////////////////////////////////////////////
    // Vertex pipeline
    ////////////////////////////////////////////////////////////

    vertex_transform #(.FRAC_BITS(FRAC_BITS)) u_xform (
        .clk       (clk),
        .rst_n     (rst_n),
        .rows      (rows),
        .vtx       (vtx),
        .vtx_valid (vtx_valid),
        .vtx_ready (vtx_ready),
        .clip      (clip),
        .clip_valid(clip_valid),
        .clip_ready(clip_ready),
        .idle      (xform_idle)
    );

    persp_divide #(.FRAC_BITS(FRAC_BITS)) u_divide (
        .clk       (clk),
        .rst_n     (rst_n),
        .clip      (clip),
        .clip_valid(clip_valid),
        .clip_ready(clip_ready),
        .ndc       (ndc),
        .ndc_valid (ndc_valid),
        .ndc_ready (ndc_ready),
        .idle      (div_idle)
    );

    viewport_map #(.FRAC_BITS(FRAC_BITS)) u_viewport (
        .clk      (clk),
        .rst_n    (rst_n),
        .vp_load  (vp_load),
        .vp_data  (vp_data),
        .ndc      (ndc),
        .ndc_valid(ndc_valid),
        .ndc_ready(ndc_ready),
        .scr      (scr),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .idle     (vp_idle)
    );

endmodule

`default_nettype wire

//--- src/viewport_map.sv
`timescale 1ns/1ns
`default_nettype none

module viewport_map #(
    parameter int FRAC_BITS = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              vp_load,
    input  geom_pkg::vec4_t   vp_data,
    input  geom_pkg::ndc_t    ndc,
    input  logic              ndc_valid,
    output logic              ndc_ready,
    output geom_pkg::screen_t scr,
    output logic              out_req,
    input  logic              out_ack,
    output logic              idle
);
    import geom_pkg::*;

    localparam coord_t ONE = coord_t'(1 << FRAC_BITS);

    typedef enum logic [1:0] {
        EMPTY,
        REQ,       // out_req high, scr stable
        WAIT_LOW   // Host still holds out_ack
    } port_state_t;

    port_state_t        state;
    vec4_t              vp_q;        // x, y, width, height
    coord_t             ndc_x1;
    coord_t             ndc_y1;
    coord_t             ndc_z1;
    logic signed [63:0] span_x;
    logic signed [63:0] span_y;
    logic signed [63:0] off_x;
    logic signed [63:0] off_y;

    ////////////////////////////////////////////////////////////
    // Screen mapping
    ////////////////////////////////////////////////////////////

    assign ndc_x1 = ndc.x + ONE;
    assign ndc_y1 = ndc.y + ONE;
    assign ndc_z1 = ndc.z + ONE;

    assign span_x = ndc_x1 * vp_q.z;            // Times width
    assign span_y = ndc_y1 * vp_q.w;            // Times height
    assign off_x  = span_x >>> (FRAC_BITS + 1); // Halved back to fixed point
    assign off_y  = span_y >>> (FRAC_BITS + 1);

    assign ndc_ready = (state == EMPTY);
    assign out_req   = (state == REQ);
    assign idle      = (state == EMPTY);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= EMPTY;
            vp_q  <= '0;
        end
        else
        begin
            if (vp_load) vp_q <= vp_data;
            case (state)
                EMPTY:    if (ndc_valid) state <= REQ;
                REQ:      if (out_ack) state <= WAIT_LOW;
                WAIT_LOW: if (!out_ack) state <= EMPTY;
                default:  state <= EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == EMPTY && ndc_valid)
        begin
            scr.x <= vp_q.x + off_x[31:0];
            scr.y <= vp_q.y + off_y[31:0];
            scr.z <= ndc_z1 >>> 1;
        end
    end

endmodule

`default_nettype wire

//--- src/persp_divide.sv
`timescale 1ns/1ns
`default_nettype none

module persp_divide #(
    parameter int FRAC_BITS = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  geom_pkg::vec4_t clip,
    input  logic            clip_valid,
    output logic            clip_ready,
    output geom_pkg::ndc_t  ndc,
    output logic            ndc_valid,
    input  logic            ndc_ready,
    output logic            idle
);
    import geom_pkg::*;

    localparam int NUM_W = 32 + FRAC_BITS;       // Iterations per divide
    localparam int CNT_W = $clog2(NUM_W + 1);

    typedef enum logic [1:0] {
        IDLE,
        DIV,
        DONE
    } div_state_t;

    div_state_t       state;
    logic [CNT_W-1:0] step;
    logic [31:0]      dvs_q;         // |w|, shared by all three lanes
    logic [31:0]      rem_q  [3];
    logic [NUM_W-1:0] quo_q  [3];
    logic [2:0]       neg_q;
    coord_t           num    [3];
    logic [32:0]      rem_sh [3];
    logic [32:0]      rem_dif [3];
    coord_t           res    [3];

    function automatic logic [31:0] magnitude(input coord_t v);
        return v[31] ? -v : v;
    endfunction

    assign num[0] = clip.x;
    assign num[1] = clip.y;
    assign num[2] = clip.z;

    ////////////////////////////////////////////////////////////
    // Restoring step, three lanes in lockstep
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < 3; i++)
        begin
            rem_sh[i]  = {rem_q[i], quo_q[i][NUM_W-1]};
            rem_dif[i] = rem_sh[i] - {1'b0, dvs_q};  // Bit 32 set means no fit
            res[i]     = neg_q[i] ? (32'd0 - quo_q[i][31:0]) : quo_q[i][31:0];
        end
    end

    assign clip_ready = (state == IDLE);
    assign ndc_valid  = (state == DONE);
    assign idle       = (state == IDLE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            step  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    step <= '0;
                    if (clip_valid) state <= DIV;
                end
                DIV:
                begin
                    step <= step + 1'b1;
                    if (step == CNT_W'(NUM_W)) state <= DONE;  // Sign cycle
                end
                DONE: if (ndc_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && clip_valid)
        begin
            dvs_q <= magnitude(clip.w);
            for (int i = 0; i < 3; i++)
            begin
                rem_q[i] <= '0;
                quo_q[i] <= {magnitude(num[i]), {FRAC_BITS{1'b0}}};
                neg_q[i] <= num[i][31];
            end
        end
        else if (state == DIV && step != CNT_W'(NUM_W))
        begin
            for (int i = 0; i < 3; i++)
            begin
                rem_q[i] <= rem_dif[i][32] ? rem_sh[i][31:0] : rem_dif[i][31:0];
                quo_q[i] <= {quo_q[i][NUM_W-2:0], ~rem_dif[i][32]};
            end
        end
        else if (state == DIV)
        begin
            ndc.x <= res[0];  // Truncated toward zero
            ndc.y <= res[1];
            ndc.z <= res[2];
        end
    end

endmodule

`default_nettype wire

//--- src/vertex_transform.sv
`timescale 1ns/1ns
`default_nettype none

module vertex_transform #(
    parameter int FRAC_BITS = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  geom_pkg::mat4_t rows,
    input  geom_pkg::vec4_t vtx,
    input  logic            vtx_valid,
    output logic            vtx_ready,
    output geom_pkg::vec4_t clip,
    output logic            clip_valid,
    input  logic            clip_ready,
    output logic            idle
);
    import geom_pkg::*;

    typedef enum logic [1:0] {
        X_IDLE,
        X_CALC,  // One row per cycle
        X_HOLD   // clip waiting for the divider
    } xf_state_t;

    xf_state_t          state;
    row_idx_t           row_cnt;
    vec4_t              vtx_q;
    vec4_t              row;
    logic signed [63:0] prod [4];
    logic signed [63:0] acc;
    logic signed [63:0] acc_sh;

    ////////////////////////////////////////////////////////////
    // Dot product of the current row with the vertex
    ////////////////////////////////////////////////////////////

    assign row = rows[row_cnt];

    assign prod[0] = row.x * vtx_q.x;  // Full 64-bit products
    assign prod[1] = row.y * vtx_q.y;
    assign prod[2] = row.z * vtx_q.z;
    assign prod[3] = row.w * vtx_q.w;

    assign acc    = prod[0] + prod[1] + prod[2] + prod[3];
    assign acc_sh = acc >>> FRAC_BITS; // Floor

    assign vtx_ready  = (state == X_IDLE);
    assign clip_valid = (state == X_HOLD);
    assign idle       = (state == X_IDLE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= X_IDLE;
            row_cnt <= '0;
        end
        else
        begin
            case (state)
                X_IDLE:
                begin
                    row_cnt <= '0;
                    if (vtx_valid) state <= X_CALC;
                end
                X_CALC:
                begin
                    row_cnt <= row_cnt + 2'd1;
                    if (row_cnt == 2'd3) state <= X_HOLD;
                end
                X_HOLD: if (clip_ready) state <= X_IDLE;
                default: state <= X_IDLE;
            endcase
        end
    end

    // Vertex latch and result components
    always_ff @(posedge clk)
    begin
        if (state == X_IDLE && vtx_valid)
            vtx_q <= vtx;
        if (state == X_CALC)
        begin
            case (row_cnt)
                2'd0: clip.x <= acc_sh[31:0];
                2'd1: clip.y <= acc_sh[31:0];
                2'd2: clip.z <= acc_sh[31:0];
                default: clip.w <= acc_sh[31:0];
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/geom_cmd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module geom_cmd_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  geom_pkg::geom_cmd_t cmd,
    input  logic                cmd_req,
    output logic                cmd_ack,
    output geom_pkg::vec4_t     vtx,
    output logic                vtx_valid,
    input  logic                vtx_ready,
    output logic                row_load,
    output geom_pkg::row_idx_t  row_sel,
    output geom_pkg::vec4_t     row_data,
    output logic                vp_load,
    output geom_pkg::vec4_t     vp_data,
    input  logic                xform_idle,
    input  logic                pipe_idle
);
    import geom_pkg::*;

    typedef enum logic {
        S_IDLE,  // Waiting for cmd_req
        S_ACK    // cmd_ack high, waiting for cmd_req to drop
    } cmd_state_t;

    cmd_state_t state;
    logic       pending;
    logic       go;

    assign pending = (state == S_IDLE) && cmd_req;

    // Ordering condition per command type
    always_comb
    begin
        case (cmd.op)
            CMD_VERTEX:       go = vtx_ready;
            CMD_LOAD_ROW:     go = xform_idle;  // Matrix in use by a vertex
            CMD_SET_VIEWPORT: go = pipe_idle;   // Older vertices drain first
            default:          go = 1'b1;        // Unknown op, just acknowledged
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Strobes, one per handshake
    ////////////////////////////////////////////////////////////

    assign vtx_valid = pending && (cmd.op == CMD_VERTEX);
    assign row_load  = pending && (cmd.op == CMD_LOAD_ROW) && xform_idle;
    assign vp_load   = pending && (cmd.op == CMD_SET_VIEWPORT) && pipe_idle;

    assign vtx      = cmd.data;
    assign row_sel  = cmd.row;
    assign row_data = cmd.data;
    assign vp_data  = cmd.data;

    assign cmd_ack = (state == S_ACK);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
        end
        else
        begin
            case (state)
                S_IDLE: if (pending && go) state <= S_ACK;
                S_ACK:  if (!cmd_req) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/matrix_store.sv
`timescale 1ns/1ns
`default_nettype none

module matrix_store (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               row_load,
    input  geom_pkg::row_idx_t row_sel,
    input  geom_pkg::vec4_t    row_data,
    output geom_pkg::mat4_t    rows
);
    import geom_pkg::*;

    ////////////////////////////////////////////////////////////
    // Transform matrix, one row written per load
    ////////////////////////////////////////////////////////////

    // Cleared at reset so an unloaded matrix maps every vertex to zero
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rows <= '0;
        end
        else if (row_load)
        begin
            rows[row_sel] <= row_data;
        end
    end

endmodule

`default_nettype wire

//--- src/geom_pkg.sv
`default_nettype none

package geom_pkg;

    ////////////////////////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////////////////////////

    typedef logic signed [31:0] coord_t;   // Two's-complement fixed point
    typedef logic [1:0]         row_idx_t; // Matrix row index

    ////////////////////////////////////////////////////////////
    // Vectors and commands
    ////////////////////////////////////////////////////////////

    // Vertex, matrix row, or viewport (x, y, width, height)
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        coord_t w;
    } vec4_t;

    typedef vec4_t [3:0] mat4_t; // Row 0 in the low slot

    typedef enum logic [1:0] {
        CMD_LOAD_ROW     = 2'd0,
        CMD_SET_VIEWPORT = 2'd1,
        CMD_VERTEX       = 2'd2
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t  op;
        row_idx_t row;   // Only used by CMD_LOAD_ROW
        vec4_t    data;
    } geom_cmd_t;

    // Divider output in normalized device coordinates
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } ndc_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;       // Depth in 0..1
    } screen_t;

endpackage

`default_nettype wire
